// File: machine_pkg.sv
package machine_pkg;

    // one machine word, as shown on the memory buffer lamps and the
    // data switch register
    localparam int word_bits = 12;

    // address within a single memory field, this is the width of pc
    localparam int addr_bits = 12;

    // extended memory field, one bit selects between the two fields
    localparam int field_bits = 1;

    // the full memory address is the field on top of pc
    localparam int mem_addr_bits = field_bits + addr_bits;

    // two fields of 4096 words each
    localparam int mem_words = 1 << mem_addr_bits;

endpackage

// File: panel_pkg.sv
package panel_pkg;

    // top bit of the debounce counter
    // the lockout ends when this bit sets, so it lasts 2**4 = 16 cycles
    localparam int dbnce_nu_bits = 4;

    // number of command switches on the panel
    localparam int sw_count = 6;

    // bit positions inside the command vector
    // a higher position also means a higher priority in the sequencer
    localparam int sw_clear     = 5;
    localparam int sw_extd_addr = 4;
    localparam int sw_addr_load = 3;
    localparam int sw_dep       = 2;
    localparam int sw_exam      = 1;
    localparam int sw_cont      = 0;

    // debounce FSM states
    // latch collects presses, the trigger is held through trig1 to trig3,
    // the switches are then locked out for the delay
    typedef enum logic [2:0] {
        tr_latch    = 3'b000,
        tr_wait     = 3'b001,
        tr_trig1    = 3'b010,
        tr_trig2    = 3'b011,
        tr_trig3    = 3'b100,
        tr_delay    = 3'b101,
        tr_reenable = 3'b110
    } trig_state_t;

    // command sequencer states
    // read_wait covers the one-cycle latency of a memory read
    typedef enum logic [1:0] {
        seq_idle      = 2'b00,
        seq_act       = 2'b01,
        seq_read_wait = 2'b10
    } seq_state_t;

endpackage

// File: front_panel.sv
module front_panel
    import panel_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic extd_addr,
    input  logic addr_load,
    input  logic dep,
    input  logic exam,
    input  logic cont,
    output logic sw_active,
    output logic triggerd,
    output logic cleard,
    output logic extd_addrd,
    output logic addr_loadd,
    output logic depd,
    output logic examd,
    output logic contd
);

    trig_state_t            trig_state;
    logic [sw_count-1:0]    sw_in;
    logic [sw_count-1:0]    switchl;
    // the trigger sits on top of the latched command bits
    logic [sw_count:0]      switchd;
    logic [dbnce_nu_bits:0] trig_cnt;

    // gather the raw switch levels into one vector
    always_comb
    begin
        sw_in               = '0;
        sw_in[sw_clear]     = clear;
        sw_in[sw_extd_addr] = extd_addr;
        sw_in[sw_addr_load] = addr_load;
        sw_in[sw_dep]       = dep;
        sw_in[sw_exam]      = exam;
        sw_in[sw_cont]      = cont;
    end

    assign triggerd   = switchd[sw_count];
    assign cleard     = switchd[sw_clear];
    assign extd_addrd = switchd[sw_extd_addr];
    assign addr_loadd = switchd[sw_addr_load];
    assign depd       = switchd[sw_dep];
    assign examd      = switchd[sw_exam];
    assign contd      = switchd[sw_cont];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_state <= tr_latch;
            switchl    <= '0;
            switchd    <= '0;
            trig_cnt   <= '0;
            sw_active  <= 1'b0;
        end
        else
        begin
            case (trig_state)
                tr_latch:
                begin
                    // any press sticks in the latch until the trigger is issued
                    switchl <= switchl | sw_in;
                    if (switchl != '0)
                        trig_state <= tr_wait;
                end
                tr_wait:
                begin
                    // hand the latched switches over together with the trigger
                    switchd    <= {1'b1, switchl};
                    switchl    <= '0;
                    trig_state <= tr_trig1;
                end
                tr_trig1:
                begin
                    trig_cnt   <= '0;
                    trig_state <= tr_trig2;
                end
                tr_trig2:
                    trig_state <= tr_trig3;
                tr_trig3:
                    trig_state <= tr_delay;
                tr_delay:
                begin
                    // the top counter bit ends the lockout
                    if (trig_cnt[dbnce_nu_bits])
                    begin
                        sw_active  <= 1'b0;
                        trig_state <= tr_reenable;
                    end
                    else
                    begin
                        // first delay cycle drops the trigger vector, which
                        // makes it four cycles wide
                        switchd   <= '0;
                        trig_cnt  <= trig_cnt + 1'b1;
                        sw_active <= 1'b1;
                    end
                end
                tr_reenable:
                    trig_state <= tr_latch;
                default:
                    trig_state <= tr_latch;
            endcase
        end
    end

    // while the trigger is held it carries at least one command bit
    assert property (@(posedge clk) disable iff (reset)
        trig_state inside {tr_trig1, tr_trig2, tr_trig3}
        |-> switchd[sw_count] && (switchd[sw_count-1:0] != '0));

    // no stale command is left on the outputs while waiting for a press
    assert property (@(posedge clk) disable iff (reset)
        trig_state inside {tr_latch, tr_wait, tr_reenable} |-> switchd == '0);

    // the lockout has always ended before new presses are latched
    assert property (@(posedge clk) disable iff (reset)
        trig_state == tr_latch |-> !sw_active);

endmodule

// File: panel_regs.sv
module panel_regs
    import machine_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  halt,
    input  logic                  load_pc,
    input  logic                  load_field,
    input  logic                  inc_pc,
    input  logic                  load_mb,
    input  logic                  clear_regs,
    input  logic                  set_run,
    input  logic [word_bits-1:0]  reg_data,
    output logic [addr_bits-1:0]  pc,
    output logic [field_bits-1:0] field,
    output logic [word_bits-1:0]  mb,
    output logic                  run
);

    // program counter
    // increment wraps inside the current field and never carries into it
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (load_pc)
            pc <= reg_data[addr_bits-1:0];
        else if (inc_pc)
            pc <= pc + addr_bits'(1);
    end

    // memory field, taken from the low bits of the data switches
    always_ff @(posedge clk)
    begin
        if (reset)
            field <= '0;
        else if (load_field)
            field <= reg_data[field_bits-1:0];
    end

    // memory buffer lamps
    // shows the word just deposited or examined
    always_ff @(posedge clk)
    begin
        if (reset)
            mb <= '0;
        else if (clear_regs)
            mb <= '0;
        else if (load_mb)
            mb <= reg_data;
    end

    // run flag
    // halt is a level and wins over continue on every cycle it is held
    always_ff @(posedge clk)
    begin
        if (reset)
            run <= 1'b0;
        else if (halt || clear_regs)
            run <= 1'b0;
        else if (set_run)
            run <= 1'b1;
    end

endmodule

// File: panel_sequencer.sv
module panel_sequencer
    import machine_pkg::*;
    import panel_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 triggerd,
    input  logic                 cleard,
    input  logic                 extd_addrd,
    input  logic                 addr_loadd,
    input  logic                 depd,
    input  logic                 examd,
    input  logic                 contd,
    input  logic [word_bits-1:0] switch_reg,
    input  logic [word_bits-1:0] mem_rdata,
    output logic                 load_pc,
    output logic                 load_field,
    output logic                 inc_pc,
    output logic                 load_mb,
    output logic                 clear_regs,
    output logic                 set_run,
    output logic [word_bits-1:0] reg_data,
    output logic                 mem_we,
    output logic [word_bits-1:0] mem_wdata
);

    seq_state_t          state;
    logic                trig_q;
    logic                trig_rise;
    logic [sw_count-1:0] cmd_in;
    logic [sw_count-1:0] cmd_pick;
    logic [sw_count-1:0] cmd_q;
    logic                in_act;
    logic                in_read;

    // reassemble the debounced command bits
    always_comb
    begin
        cmd_in               = '0;
        cmd_in[sw_clear]     = cleard;
        cmd_in[sw_extd_addr] = extd_addrd;
        cmd_in[sw_addr_load] = addr_loadd;
        cmd_in[sw_dep]       = depd;
        cmd_in[sw_exam]      = examd;
        cmd_in[sw_cont]      = contd;
    end

    // the trigger is held for four cycles, only its first cycle counts
    assign trig_rise = triggerd & ~trig_q;

    // keep only the highest priority command when several were latched
    always_comb
    begin
        cmd_pick = '0;
        if (cmd_in[sw_clear])
            cmd_pick[sw_clear] = 1'b1;
        else if (cmd_in[sw_extd_addr])
            cmd_pick[sw_extd_addr] = 1'b1;
        else if (cmd_in[sw_addr_load])
            cmd_pick[sw_addr_load] = 1'b1;
        else if (cmd_in[sw_dep])
            cmd_pick[sw_dep] = 1'b1;
        else if (cmd_in[sw_exam])
            cmd_pick[sw_exam] = 1'b1;
        else if (cmd_in[sw_cont])
            cmd_pick[sw_cont] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= seq_idle;
            trig_q <= 1'b0;
            cmd_q  <= '0;
        end
        else
        begin
            trig_q <= triggerd;
            case (state)
                seq_idle:
                begin
                    if (trig_rise)
                    begin
                        cmd_q <= cmd_pick;
                        state <= seq_act;
                    end
                end
                seq_act:
                begin
                    // examine has to wait a cycle for the read word
                    if (cmd_q[sw_exam])
                        state <= seq_read_wait;
                    else
                        state <= seq_idle;
                end
                seq_read_wait:
                    state <= seq_idle;
                default:
                    state <= seq_idle;
            endcase
        end
    end

    assign in_act  = (state == seq_act);
    assign in_read = (state == seq_read_wait);

    assign clear_regs = in_act & cmd_q[sw_clear];
    assign load_field = in_act & cmd_q[sw_extd_addr];
    assign load_pc    = in_act & cmd_q[sw_addr_load];
    assign set_run    = in_act & cmd_q[sw_cont];

    // deposit writes at the current address while pc steps past it
    assign mem_we    = in_act & cmd_q[sw_dep];
    assign mem_wdata = switch_reg;

    // both deposit and examine show the word on the lamps and advance pc
    assign load_mb = mem_we | in_read;
    assign inc_pc  = load_mb;

    // examine loads the memory word, everything else the switches
    assign reg_data = in_read ? mem_rdata : switch_reg;

    // a new trigger always carries a command from the debounce logic
    assert property (@(posedge clk) disable iff (reset)
        trig_rise |-> cmd_in != '0);

    // one panel command drives one register action per cycle
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({load_pc, load_field, load_mb, clear_regs, set_run}));

endmodule

// File: core_memory.sv
module core_memory
    import machine_pkg::*;
(
    input  logic                     clk,
    input  logic                     we,
    input  logic [mem_addr_bits-1:0] addr,
    input  logic [word_bits-1:0]     wdata,
    output logic [word_bits-1:0]     rdata
);

    logic [word_bits-1:0] mem [mem_words];

    // start from an empty memory in simulation
    initial
    begin
        foreach (mem[i])
            mem[i] = '0;
    end

    // single port, the read returns the old word on a write cycle
    // read data appears one cycle after the address
    always @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

// File: panel_top.sv
module panel_top
    import machine_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [word_bits-1:0]  switch_reg,
    input  logic                  clear,
    input  logic                  extd_addr,
    input  logic                  addr_load,
    input  logic                  dep,
    input  logic                  exam,
    input  logic                  cont,
    input  logic                  halt,
    output logic [addr_bits-1:0]  pc,
    output logic [field_bits-1:0] field,
    output logic [word_bits-1:0]  mb,
    output logic                  run,
    output logic                  sw_active
);

    logic                     triggerd;
    logic                     cleard;
    logic                     extd_addrd;
    logic                     addr_loadd;
    logic                     depd;
    logic                     examd;
    logic                     contd;
    logic                     load_pc;
    logic                     load_field;
    logic                     inc_pc;
    logic                     load_mb;
    logic                     clear_regs;
    logic                     set_run;
    logic [word_bits-1:0]     reg_data;
    logic                     mem_we;
    logic [word_bits-1:0]     mem_wdata;
    logic [word_bits-1:0]     mem_rdata;
    logic [mem_addr_bits-1:0] mem_addr;

    // the memory is always addressed by the panel field and pc
    assign mem_addr = {field, pc};

    front_panel front_panel_inst (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .extd_addr  (extd_addr),
        .addr_load  (addr_load),
        .dep        (dep),
        .exam       (exam),
        .cont       (cont),
        .sw_active  (sw_active),
        .triggerd   (triggerd),
        .cleard     (cleard),
        .extd_addrd (extd_addrd),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .contd      (contd)
    );

    panel_sequencer panel_sequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .triggerd   (triggerd),
        .cleard     (cleard),
        .extd_addrd (extd_addrd),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .contd      (contd),
        .switch_reg (switch_reg),
        .mem_rdata  (mem_rdata),
        .load_pc    (load_pc),
        .load_field (load_field),
        .inc_pc     (inc_pc),
        .load_mb    (load_mb),
        .clear_regs (clear_regs),
        .set_run    (set_run),
        .reg_data   (reg_data),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata)
    );

    panel_regs panel_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .halt       (halt),
        .load_pc    (load_pc),
        .load_field (load_field),
        .inc_pc     (inc_pc),
        .load_mb    (load_mb),
        .clear_regs (clear_regs),
        .set_run    (set_run),
        .reg_data   (reg_data),
        .pc         (pc),
        .field      (field),
        .mb         (mb),
        .run        (run)
    );

    core_memory core_memory_inst (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: tb_panel_top.sv
module tb_panel_top
    import machine_pkg::*;
    import panel_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [word_bits-1:0]  switch_reg;
    logic                  clear;
    logic                  extd_addr;
    logic                  addr_load;
    logic                  dep;
    logic                  exam;
    logic                  cont;
    logic                  halt;
    logic [addr_bits-1:0]  pc;
    logic [field_bits-1:0] field;
    logic [word_bits-1:0]  mb;
    logic                  run;
    logic                  sw_active;

    // reference model of the panel registers and the memory
    logic [word_bits-1:0]  m_mem [mem_words];
    logic [addr_bits-1:0]  m_pc;
    logic [field_bits-1:0] m_field;
    logic [word_bits-1:0]  m_mb;
    logic                  m_run;

    logic [15:0] lfsr = 16'd15;
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors;

    panel_top panel_top_inst (.*);

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, shifted in at the bottom
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step for every bit taken
    function automatic logic [15:0] draw_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // all stimulus changes a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic set_switches(input logic [sw_count-1:0] cmd);
        clear     = cmd[sw_clear];
        extd_addr = cmd[sw_extd_addr];
        addr_load = cmd[sw_addr_load];
        dep       = cmd[sw_dep];
        exam      = cmd[sw_exam];
        cont      = cmd[sw_cont];
    endtask

    task automatic drive_press(input logic [sw_count-1:0] cmd,
                               input logic [word_bits-1:0] sw, input int hold);
        switch_reg = sw;
        set_switches(cmd);
        repeat (hold)
            next_cycle();
        set_switches('0);
    endtask

    task automatic wait_active(input logic level, input int limit);
        int n;
        n = 0;
        while (sw_active !== level && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (sw_active !== level)
        begin
            $display("timeout: sw_active did not go to %b within %0d cycles", level, limit);
            $display("checks %0d, errors %0d", check_count, error_count);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    // only the highest priority latched switch acts
    task automatic model_apply(input logic [sw_count-1:0] cmd,
                               input logic [word_bits-1:0] sw);
        if (cmd[sw_clear])
        begin
            m_mb  = '0;
            m_run = 1'b0;
        end
        else if (cmd[sw_extd_addr])
            m_field = sw[field_bits-1:0];
        else if (cmd[sw_addr_load])
            m_pc = sw[addr_bits-1:0];
        else if (cmd[sw_dep])
        begin
            m_mem[{m_field, m_pc}] = sw;
            m_mb = sw;
            m_pc = m_pc + 1'b1;
        end
        else if (cmd[sw_exam])
        begin
            m_mb = m_mem[{m_field, m_pc}];
            m_pc = m_pc + 1'b1;
        end
        else if (cmd[sw_cont])
            m_run = 1'b1;
        if (halt)
            m_run = 1'b0;
    endtask

    task automatic check_state();
        check_value("pc", 16'(pc), 16'(m_pc));
        check_value("field", 16'(field), 16'(m_field));
        check_value("mb", 16'(mb), 16'(m_mb));
        check_value("run", 16'(run), 16'(m_run));
    endtask

    // the lockout runs 2**dbnce_nu_bits cycles, a few more cover the trigger
    // the latch only reopens one cycle after sw_active falls
    task automatic do_press(input logic [sw_count-1:0] cmd,
                            input logic [word_bits-1:0] sw, input int hold);
        drive_press(cmd, sw, hold);
        wait_active(1'b1, 12);
        wait_active(1'b0, (1 << dbnce_nu_bits) + 8);
        next_cycle();
        model_apply(cmd, sw);
        check_state();
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    initial
    begin
        logic [sw_count-1:0]  cmd;
        logic [2:0]           pick;
        logic [word_bits-1:0] sw;
        foreach (m_mem[i])
            m_mem[i] = '0;
        m_pc = '0;
        m_field = '0;
        m_mb = '0;
        m_run = 1'b0;
        reset = 1'b1;
        switch_reg = '0;
        halt = 1'b0;
        set_switches('0);
        repeat (10)
            next_cycle();
        reset = 1'b0;
        next_cycle();
        test_errors = 0;

        do_press(1 << sw_extd_addr, 12'o0001, 1);
        do_press(1 << sw_addr_load, 12'o7776, 2);
        end_test("load address and field");

        // four deposits cross the top of field 1
        for (int i = 0; i < 4; i++)
            do_press(1 << sw_dep, 12'o1000 + 12'(i * 7), 1 + i % 3);
        end_test("deposit");

        do_press(1 << sw_addr_load, 12'o7776, 1);
        for (int i = 0; i < 4; i++)
            do_press(1 << sw_exam, 12'o0000, 2);
        end_test("examine");

        // a press during the lockout is dropped
        drive_press(1 << sw_addr_load, 12'o0100, 1);
        wait_active(1'b1, 12);
        drive_press(1 << sw_dep, 12'o4321, 3);
        wait_active(1'b0, (1 << dbnce_nu_bits) + 8);
        model_apply(1 << sw_addr_load, 12'o0100);
        check_state();
        // a deposit caught in the latch would raise sw_active again within seven cycles
        repeat (8)
        begin
            next_cycle();
            check_value("sw_active", 16'(sw_active), 16'd0);
        end
        check_state();
        // dep, exam and cont together act as a deposit
        cmd = '0;
        cmd[sw_dep] = 1'b1;
        cmd[sw_exam] = 1'b1;
        cmd[sw_cont] = 1'b1;
        do_press(cmd, 12'o5252, 2);
        end_test("lockout and priority");

        do_press(1 << sw_cont, 12'o0000, 1);
        halt = 1'b1;
        m_run = 1'b0;
        next_cycle();
        check_state();
        do_press(1 << sw_cont, 12'o0000, 1);
        halt = 1'b0;
        next_cycle();
        check_state();
        do_press(1 << sw_cont, 12'o0000, 1);
        do_press(1 << sw_clear, 12'o0000, 1);
        end_test("continue, halt and clear");

        for (int n = 0; n < 200; n++)
        begin
            pick = draw_bits(3);
            if (pick < sw_count)
                cmd = 1 << pick;
            else
                cmd = draw_bits(sw_count);
            if (cmd == '0)
                cmd[sw_cont] = 1'b1;
            sw = draw_bits(word_bits);
            halt = (draw_bits(3) == 0);
            do_press(cmd, sw, 1 + int'(draw_bits(2)) % 3);
        end
        halt = 1'b0;
        end_test("random sequence");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: flist.f
machine_pkg.sv
panel_pkg.sv
front_panel.sv
panel_regs.sv
panel_sequencer.sv
core_memory.sv
panel_top.sv
tb_panel_top.sv
